/* common/noc_pkg.sv */
package noc_pkg;

   // width of one flit on every physical network
   localparam int NOC_DATA_WIDTH = 64;

   // noc1 noc2 noc3
   localparam int NOC_CHANNELS = 3;

   typedef logic [NOC_DATA_WIDTH-1:0] flit_t;

   // off-chip side of a channel
   // ready travels back on its own wire
   typedef struct packed
   {
      logic  valid;
      flit_t data;
   } noc_vr_t;

   // tile side of a channel
   // yummy travels back on its own wire
   typedef struct packed
   {
      logic  valid;
      flit_t data;
   } noc_cr_t;

endpackage

/* common/flow_pkg.sv */
package flow_pkg;

   // slots in each converter buffer
   localparam int DEFAULT_BUF_DEPTH = 4;

   // matches the input buffer depth of the tile router
   localparam int DEFAULT_CREDITS = 4;

endpackage

/* credit_bridge/flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo
   import noc_pkg::*, flow_pkg::*;
#(
   parameter int BUF_DEPTH = DEFAULT_BUF_DEPTH
)
(
   input  logic  io_clk_inter,
   input  logic  rst_n_inter_sync_f,
   input  logic  push_i,
   input  flit_t push_data_i,
   input  logic  pop_i,
   output flit_t head_o,
   output logic  empty_o,
   output logic  full_o
);

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   flit_t            mem [BUF_DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // wraps for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(BUF_DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign empty_o = (count == '0);
   assign full_o  = (count == CNT_W'(BUF_DEPTH));
   assign do_pop  = pop_i && !empty_o;
   // a full buffer still takes a flit when the head leaves in the same cycle
   assign do_push = push_i && (!full_o || do_pop);
   assign head_o  = mem[rd_ptr];

   always_ff @(posedge io_clk_inter)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge io_clk_inter)
   begin
      if (!rst_n_inter_sync_f)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop)
         begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         if (do_push && !do_pop)
         begin
            count <= count + 1'b1;
         end
         else if (do_pop && !do_push)
         begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* credit_bridge/valrdy_to_credit.sv */
`timescale 1ns/1ps

module valrdy_to_credit
   import noc_pkg::*, flow_pkg::*;
#(
   parameter int BUF_DEPTH = DEFAULT_BUF_DEPTH,
   parameter int CREDITS   = DEFAULT_CREDITS
)
(
   input  logic    io_clk_inter,
   input  logic    rst_n_inter_sync_f,

   input  noc_vr_t in_i,
   output logic    in_ready_o,

   output noc_cr_t out_o,
   input  logic    out_yummy_i
);

   localparam int CRED_W = $clog2(CREDITS + 1);

   flit_t             head;
   logic              empty;
   logic              full;
   logic              send;
   logic [CRED_W-1:0] credit_cnt;

   assign in_ready_o = !full;

   // one flit per valid cycle and only with a credit in hand
   assign send        = !empty && (credit_cnt != '0);
   assign out_o.valid = send;
   assign out_o.data  = head;

   // a flit moves only when valid meets ready
   flit_fifo #(
      .BUF_DEPTH (BUF_DEPTH)
   ) u_buf (
      .io_clk_inter       (io_clk_inter),
      .rst_n_inter_sync_f (rst_n_inter_sync_f),
      .push_i             (in_i.valid && !full),
      .push_data_i        (in_i.data),
      .pop_i              (send),
      .head_o             (head),
      .empty_o            (empty),
      .full_o             (full)
   );

   // free slots in the tile router input buffer
   always_ff @(posedge io_clk_inter)
   begin
      if (!rst_n_inter_sync_f)
      begin
         credit_cnt <= CRED_W'(CREDITS);
      end
      else
      begin
         if (out_yummy_i && !send)
         begin
            // saturate at the router depth
            if (credit_cnt != CRED_W'(CREDITS))
            begin
               credit_cnt <= credit_cnt + 1'b1;
            end
         end
         else if (send && !out_yummy_i)
         begin
            credit_cnt <= credit_cnt - 1'b1;
         end
      end
   end

endmodule

/* credit_bridge/credit_to_valrdy.sv */
`timescale 1ns/1ps

module credit_to_valrdy
   import noc_pkg::*, flow_pkg::*;
#(
   parameter int BUF_DEPTH = DEFAULT_BUF_DEPTH
)
(
   input  logic    io_clk_inter,
   input  logic    rst_n_inter_sync_f,

   input  noc_cr_t in_i,
   output logic    in_yummy_o,

   output noc_vr_t out_o,
   input  logic    out_ready_i
);

   flit_t head;
   logic  empty;
   logic  xfer;
   logic  yummy_q;

   // head stays put while ready is low
   assign out_o.valid = !empty;
   assign out_o.data  = head;
   assign xfer        = !empty && out_ready_i;
   assign in_yummy_o  = yummy_q;

   // the tile only sends under credit so every valid finds a free slot
   flit_fifo #(
      .BUF_DEPTH (BUF_DEPTH)
   ) u_buf (
      .io_clk_inter       (io_clk_inter),
      .rst_n_inter_sync_f (rst_n_inter_sync_f),
      .push_i             (in_i.valid),
      .push_data_i        (in_i.data),
      .pop_i              (xfer),
      .head_o             (head),
      .empty_o            (empty),
      .full_o             ()
   );

   // slot freed one cycle after the off-chip transfer
   always_ff @(posedge io_clk_inter)
   begin
      if (!rst_n_inter_sync_f)
      begin
         yummy_q <= 1'b0;
      end
      else
      begin
         yummy_q <= xfer;
      end
   end

endmodule

/* source/chip_noc_port.sv */
`timescale 1ns/1ps

module chip_noc_port
   import noc_pkg::*, flow_pkg::*;
#(
   parameter int BUF_DEPTH = DEFAULT_BUF_DEPTH,
   parameter int CREDITS   = DEFAULT_CREDITS
)
(
   input  logic                         io_clk_inter,
   input  logic                         rst_n_inter_sync_f,

   // off-chip into the mesh
   input  noc_vr_t [NOC_CHANNELS-1:0]   offchip_in_i,
   output logic    [NOC_CHANNELS-1:0]   offchip_in_ready_o,
   output noc_cr_t [NOC_CHANNELS-1:0]   tile_in_o,
   input  logic    [NOC_CHANNELS-1:0]   tile_in_yummy_i,

   // mesh out to off-chip
   input  noc_cr_t [NOC_CHANNELS-1:0]   tile_out_i,
   output logic    [NOC_CHANNELS-1:0]   tile_out_yummy_o,
   output noc_vr_t [NOC_CHANNELS-1:0]   offchip_out_o,
   input  logic    [NOC_CHANNELS-1:0]   offchip_out_ready_i
);

   // index 0 is noc1
   for (genvar ch = 0; ch < NOC_CHANNELS; ch++)
   begin : g_chan
      valrdy_to_credit #(
         .BUF_DEPTH (BUF_DEPTH),
         .CREDITS   (CREDITS)
      ) u_v2c (
         .io_clk_inter       (io_clk_inter),
         .rst_n_inter_sync_f (rst_n_inter_sync_f),
         .in_i               (offchip_in_i[ch]),
         .in_ready_o         (offchip_in_ready_o[ch]),
         .out_o              (tile_in_o[ch]),
         .out_yummy_i        (tile_in_yummy_i[ch])
      );

      credit_to_valrdy #(
         .BUF_DEPTH (BUF_DEPTH)
      ) u_c2v (
         .io_clk_inter       (io_clk_inter),
         .rst_n_inter_sync_f (rst_n_inter_sync_f),
         .in_i               (tile_out_i[ch]),
         .in_yummy_o         (tile_out_yummy_o[ch]),
         .out_o              (offchip_out_o[ch]),
         .out_ready_i        (offchip_out_ready_i[ch])
      );
   end

endmodule

/* bench/chip_noc_port_properties.sv */
`timescale 1ns/1ps

module chip_noc_port_properties
   import noc_pkg::*, flow_pkg::*;
#(
   parameter int BUF_DEPTH = DEFAULT_BUF_DEPTH,
   parameter int CREDITS   = DEFAULT_CREDITS
)
(
   input logic                       io_clk_inter,
   input logic                       rst_n_inter_sync_f,
   input noc_vr_t [NOC_CHANNELS-1:0] offchip_in_i,
   input logic    [NOC_CHANNELS-1:0] offchip_in_ready_i,
   input noc_cr_t [NOC_CHANNELS-1:0] tile_in_i,
   input logic    [NOC_CHANNELS-1:0] tile_in_yummy_i,
   input noc_cr_t [NOC_CHANNELS-1:0] tile_out_i,
   input logic    [NOC_CHANNELS-1:0] tile_out_yummy_i,
   input noc_vr_t [NOC_CHANNELS-1:0] offchip_out_i,
   input logic    [NOC_CHANNELS-1:0] offchip_out_ready_i
);

   // deeper than anything in flight through one converter
   localparam int SB_DEPTH = 16;
   localparam int SB_W     = 4;

   int fail_cnt = 0;

   flit_t in_sb  [NOC_CHANNELS][SB_DEPTH];
   flit_t out_sb [NOC_CHANNELS][SB_DEPTH];
   int    in_wr  [NOC_CHANNELS];
   int    in_rd  [NOC_CHANNELS];
   int    out_wr [NOC_CHANNELS];
   int    out_rd [NOC_CHANNELS];
   int    cr_out [NOC_CHANNELS];
   logic  [NOC_CHANNELS-1:0] xfer_q;
   logic  [NOC_CHANNELS-1:0] hold_q;
   flit_t held_q [NOC_CHANNELS];
   logic  rst_q;
   logic  [NOC_CHANNELS-1:0] in_valid;
   logic  [NOC_CHANNELS-1:0] out_valid;

   always @(posedge io_clk_inter)
   begin
      rst_q <= rst_n_inter_sync_f;
      if (!rst_n_inter_sync_f)
      begin
         for (int c = 0; c < NOC_CHANNELS; c++)
         begin
            in_wr[c]  <= 0;
            in_rd[c]  <= 0;
            out_wr[c] <= 0;
            out_rd[c] <= 0;
            cr_out[c] <= 0;
            xfer_q[c] <= 1'b0;
            hold_q[c] <= 1'b0;
         end
      end
      else
      begin
         for (int c = 0; c < NOC_CHANNELS; c++)
         begin
            if (offchip_in_i[c].valid && offchip_in_ready_i[c])
            begin
               in_sb[c][in_wr[c][SB_W-1:0]] <= offchip_in_i[c].data;
               in_wr[c] <= in_wr[c] + 1;
            end
            if (tile_in_i[c].valid)
            begin
               in_rd[c] <= in_rd[c] + 1;
            end
            if (tile_out_i[c].valid)
            begin
               out_sb[c][out_wr[c][SB_W-1:0]] <= tile_out_i[c].data;
               out_wr[c] <= out_wr[c] + 1;
            end
            if (offchip_out_i[c].valid && offchip_out_ready_i[c])
            begin
               out_rd[c] <= out_rd[c] + 1;
            end
            // flits sitting in the tile router input buffer
            cr_out[c] <= cr_out[c] + int'(tile_in_i[c].valid) - int'(tile_in_yummy_i[c]);
            xfer_q[c] <= offchip_out_i[c].valid && offchip_out_ready_i[c];
            hold_q[c] <= offchip_out_i[c].valid && !offchip_out_ready_i[c];
            held_q[c] <= offchip_out_i[c].data;
         end
      end
   end

   for (genvar ch = 0; ch < NOC_CHANNELS; ch++)
   begin : g_chk
      flit_t in_exp;
      flit_t out_exp;

      assign in_exp        = in_sb[ch][in_rd[ch][SB_W-1:0]];
      assign out_exp       = out_sb[ch][out_rd[ch][SB_W-1:0]];
      assign in_valid[ch]  = tile_in_i[ch].valid;
      assign out_valid[ch] = offchip_out_i[ch].valid;

      a_in_pending: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         tile_in_i[ch].valid |-> in_wr[ch] != in_rd[ch])
      else
      begin
         $error("tile_in_o[%0d] sent a flit that was never accepted off-chip", ch);
         fail_cnt++;
      end

      a_in_data: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         tile_in_i[ch].valid |-> tile_in_i[ch].data == in_exp)
      else
      begin
         $error("mismatch t=%0t tile_in_o[%0d].data exp=%h got=%h",
                $time, ch, $sampled(in_exp), $sampled(tile_in_i[ch].data));
         fail_cnt++;
      end

      // channel number rides in the top byte
      a_in_tag: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         tile_in_i[ch].valid |-> tile_in_i[ch].data[NOC_DATA_WIDTH-1 -: 8] == 8'(ch))
      else
      begin
         $error("mismatch t=%0t tile_in_o[%0d].data tag exp=%0d got=%0d",
                $time, ch, ch, $sampled(tile_in_i[ch].data[NOC_DATA_WIDTH-1 -: 8]));
         fail_cnt++;
      end

      a_credit: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         cr_out[ch] <= CREDITS)
      else
      begin
         $error("tile_in_o[%0d] has more flits outstanding than the %0d credits", ch, CREDITS);
         fail_cnt++;
      end

      a_in_ready: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         offchip_in_ready_i[ch] == ((in_wr[ch] - in_rd[ch]) < BUF_DEPTH))
      else
      begin
         $error("mismatch t=%0t offchip_in_ready_o[%0d] exp=%0b got=%0b", $time, ch,
                $sampled((in_wr[ch] - in_rd[ch]) < BUF_DEPTH), $sampled(offchip_in_ready_i[ch]));
         fail_cnt++;
      end

      a_out_data: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         (offchip_out_i[ch].valid && offchip_out_ready_i[ch])
            |-> out_wr[ch] != out_rd[ch] && offchip_out_i[ch].data == out_exp)
      else
      begin
         $error("mismatch t=%0t offchip_out_o[%0d].data exp=%h got=%h",
                $time, ch, $sampled(out_exp), $sampled(offchip_out_i[ch].data));
         fail_cnt++;
      end

      a_out_hold: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         hold_q[ch] |-> offchip_out_i[ch].valid && offchip_out_i[ch].data == held_q[ch])
      else
      begin
         $error("mismatch t=%0t offchip_out_o[%0d].data exp=%h got=%h (valid=%0b)",
                $time, ch, $sampled(held_q[ch]), $sampled(offchip_out_i[ch].data),
                $sampled(offchip_out_i[ch].valid));
         fail_cnt++;
      end

      a_yummy: assert property (@(posedge io_clk_inter) disable iff (!rst_n_inter_sync_f)
         tile_out_yummy_i[ch] == xfer_q[ch])
      else
      begin
         $error("mismatch t=%0t tile_out_yummy_o[%0d] exp=%0b got=%0b",
                $time, ch, $sampled(xfer_q[ch]), $sampled(tile_out_yummy_i[ch]));
         fail_cnt++;
      end
   end

   // first cycle out of reset
   a_reset_idle: assert property (@(posedge io_clk_inter)
      (rst_n_inter_sync_f && !rst_q) |->
         (in_valid == '0 && out_valid == '0 && tile_out_yummy_i == '0 && &offchip_in_ready_i))
   else
   begin
      $error("outputs were not idle in the first cycle after reset");
      fail_cnt++;
   end

endmodule

bind chip_noc_port chip_noc_port_properties #(
   .BUF_DEPTH (BUF_DEPTH),
   .CREDITS   (CREDITS)
) u_props (
   .io_clk_inter        (io_clk_inter),
   .rst_n_inter_sync_f  (rst_n_inter_sync_f),
   .offchip_in_i        (offchip_in_i),
   .offchip_in_ready_i  (offchip_in_ready_o),
   .tile_in_i           (tile_in_o),
   .tile_in_yummy_i     (tile_in_yummy_i),
   .tile_out_i          (tile_out_i),
   .tile_out_yummy_i    (tile_out_yummy_o),
   .offchip_out_i       (offchip_out_o),
   .offchip_out_ready_i (offchip_out_ready_i)
);

/* bench/tb_chip_noc_port.sv */
`timescale 1ns/1ps

module tb_chip_noc_port
   import noc_pkg::*, flow_pkg::*;
();

   localparam int PERIOD       = 40;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 16;
   localparam int IDLE_CYCLES  = 4;
   localparam int TEST_CYCLES  = 2000;
   localparam int DRAIN_CYCLES = 20;
   localparam int MARGIN       = 200;

   logic io_clk_inter;
   logic rst_n_inter_sync_f;

   noc_vr_t [NOC_CHANNELS-1:0] offchip_in;
   logic    [NOC_CHANNELS-1:0] offchip_in_ready;
   noc_cr_t [NOC_CHANNELS-1:0] tile_in;
   logic    [NOC_CHANNELS-1:0] tile_in_yummy;
   noc_cr_t [NOC_CHANNELS-1:0] tile_out;
   logic    [NOC_CHANNELS-1:0] tile_out_yummy;
   noc_vr_t [NOC_CHANNELS-1:0] offchip_out;
   logic    [NOC_CHANNELS-1:0] offchip_out_ready;

   int   in_seq        [NOC_CHANNELS];
   int   out_seq       [NOC_CHANNELS];
   int   rx_pending    [NOC_CHANNELS];
   int   rx_pause      [NOC_CHANNELS];
   int   tx_credits    [NOC_CHANNELS];
   logic in_ready_seen [NOC_CHANNELS];

   chip_noc_port dut (
      .io_clk_inter        (io_clk_inter),
      .rst_n_inter_sync_f  (rst_n_inter_sync_f),
      .offchip_in_i        (offchip_in),
      .offchip_in_ready_o  (offchip_in_ready),
      .tile_in_o           (tile_in),
      .tile_in_yummy_i     (tile_in_yummy),
      .tile_out_i          (tile_out),
      .tile_out_yummy_o    (tile_out_yummy),
      .offchip_out_o       (offchip_out),
      .offchip_out_ready_i (offchip_out_ready)
   );

   always #(PERIOD / 2) io_clk_inter = !io_clk_inter;

   // channel in the top byte, sequence number in the low word
   function automatic flit_t make_flit(input int ch, input int seq);
      return {8'(ch), 24'($urandom), 32'(seq)};
   endfunction

   task automatic idle_inputs();
      offchip_in        = '0;
      tile_in_yummy     = '0;
      tile_out          = '0;
      offchip_out_ready = '0;
   endtask

   task automatic reset_models();
      for (int ch = 0; ch < NOC_CHANNELS; ch++)
      begin
         in_seq[ch]        = 0;
         out_seq[ch]       = 0;
         rx_pending[ch]    = 0;
         rx_pause[ch]      = 0;
         tx_credits[ch]    = DEFAULT_BUF_DEPTH;
         in_ready_seen[ch] = 1'b0;
      end
   endtask

   // valid holds with its flit until ready takes it
   task automatic drive_offchip_source(input int ch);
      if (!offchip_in[ch].valid || in_ready_seen[ch])
      begin
         if ($urandom % 4 != 0)
         begin
            offchip_in[ch].valid = 1'b1;
            offchip_in[ch].data  = make_flit(ch, in_seq[ch]);
            in_seq[ch]++;
         end
         else
         begin
            offchip_in[ch].valid = 1'b0;
         end
      end
      // ready only moves on a clock edge
      in_ready_seen[ch] = offchip_in_ready[ch];
   endtask

   // tile router draining its input buffer, with long stalls
   task automatic drive_tile_receiver(input int ch);
      tile_in_yummy[ch] = 1'b0;
      if (rx_pause[ch] > 0)
      begin
         rx_pause[ch]--;
      end
      else if ($urandom % 64 == 0)
      begin
         rx_pause[ch] = 20 + int'($urandom % 40);
      end
      else if (rx_pending[ch] > 0 && ($urandom % 2 == 0))
      begin
         tile_in_yummy[ch] = 1'b1;
         rx_pending[ch]--;
      end
      rx_pending[ch] += int'(tile_in[ch].valid);
   endtask

   // tile router sending out under its own credits
   task automatic drive_tile_sender(input int ch);
      tx_credits[ch] += int'(tile_out_yummy[ch]);
      if (tx_credits[ch] > 0 && ($urandom % 2 == 0))
      begin
         tile_out[ch].valid = 1'b1;
         tile_out[ch].data  = make_flit(ch, out_seq[ch]);
         out_seq[ch]++;
         tx_credits[ch]--;
      end
      else
      begin
         tile_out[ch].valid = 1'b0;
      end
   endtask

   task automatic drive_cycle();
      for (int ch = 0; ch < NOC_CHANNELS; ch++)
      begin
         drive_offchip_source(ch);
         drive_tile_receiver(ch);
         drive_tile_sender(ch);
         offchip_out_ready[ch] = ($urandom % 3 != 0);
      end
   endtask

   initial
   begin
      void'($urandom(97772));
      io_clk_inter       = 1'b0;
      rst_n_inter_sync_f = 1'b0;
      idle_inputs();
      reset_models();
      repeat (RESET_CYCLES) @(posedge io_clk_inter);
      #DRIVE_DELAY;
      rst_n_inter_sync_f = 1'b1;
      repeat (IDLE_CYCLES) @(posedge io_clk_inter);
      for (int cyc = 0; cyc < TEST_CYCLES; cyc++)
      begin
         @(posedge io_clk_inter);
         #DRIVE_DELAY;
         drive_cycle();
      end
      @(posedge io_clk_inter);
      #DRIVE_DELAY;
      idle_inputs();
      repeat (DRAIN_CYCLES) @(posedge io_clk_inter);
      if (dut.u_props.fail_cnt == 0)
      begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
      else
      begin
         $display("CHECKS FAILED");
         $fatal(1, "assertion failures were seen during the run");
      end
   end

   // stop at the first failing assertion
   initial
   begin
      wait (dut.u_props.fail_cnt != 0);
      $display("CHECKS FAILED");
      $fatal(1, "an assertion failed, run stopped");
   end

   initial
   begin
      #(PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN));
      $display("CHECKS FAILED");
      $fatal(1, "timeout: the run did not finish in the expected time");
   end

endmodule

/* project.f */
common/noc_pkg.sv
common/flow_pkg.sv
credit_bridge/flit_fifo.sv
credit_bridge/valrdy_to_credit.sv
credit_bridge/credit_to_valrdy.sv
source/chip_noc_port.sv
bench/chip_noc_port_properties.sv
bench/tb_chip_noc_port.sv

/* Makefile */
SIM      := verilator
TOP      := tb_chip_noc_port
FILELIST := project.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD)
RUNARGS  := +verilator+error+limit+1000
LOG      := sim.log
FAIL_MSG := CHECKS FAILED

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) $(RUNARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
